/* hdl/issue_pkg.sv */
// micro-ops are flat words with rd in the low bits; the tag is opaque; queue depth must be a power of two, at least 4
`default_nettype none

package issue_pkg;

  // register file
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;

  // micro-op classes
  localparam int UOP_CLS_W = 3;
  localparam logic [UOP_CLS_W-1:0] CLS_ALU    = 3'd0;
  localparam logic [UOP_CLS_W-1:0] CLS_LOAD   = 3'd1;
  localparam logic [UOP_CLS_W-1:0] CLS_STORE  = 3'd2;
  localparam logic [UOP_CLS_W-1:0] CLS_BRANCH = 3'd3;
  localparam logic [UOP_CLS_W-1:0] CLS_MULDIV = 3'd4;
  localparam logic [UOP_CLS_W-1:0] CLS_CSR    = 3'd5;

  localparam int UOP_TAG_W = 8;

  // field layout, lowest field first
  localparam int UOP_RD_LSB  = 0;
  localparam int UOP_RS1_LSB = UOP_RD_LSB + REG_IDX_W;
  localparam int UOP_RS2_LSB = UOP_RS1_LSB + REG_IDX_W;
  localparam int UOP_CLS_LSB = UOP_RS2_LSB + REG_IDX_W;
  localparam int UOP_TAG_LSB = UOP_CLS_LSB + UOP_CLS_W;

  // 26 bits with the default widths
  localparam int UOP_W = UOP_TAG_LSB + UOP_TAG_W;

  // forwarding select per source operand
  localparam int FWD_W = 2;
  localparam logic [FWD_W-1:0] FWD_NONE  = 2'd0;
  localparam logic [FWD_W-1:0] FWD_SLOT0 = 2'd1;
  localparam logic [FWD_W-1:0] FWD_SLOT1 = 2'd2;

  localparam int DEF_QUEUE_DEPTH = 8;

endpackage

`default_nettype wire

/* hdl/uop_queue_if.sv */
// pop must never exceed avail; head1 is only meaningful when avail is 2
`default_nettype none

interface uop_queue_if;

  // oldest and second-oldest entries
  logic [issue_pkg::UOP_W-1:0] head0;
  logic [issue_pkg::UOP_W-1:0] head1;

  // valid heads, saturates at 2
  logic [1:0] avail;

  // entries retired at the next edge
  logic [1:0] pop;

  modport queue (
    output head0,
    output head1,
    output avail,
    input  pop
  );

  modport issue (
    input  head0,
    input  head1,
    input  avail,
    output pop
  );

endinterface

`default_nettype wire

/* hdl/scb_if.sv */
// fwd words carry rs1 in the low field and rs2 in the high field; stall and fwd are combinational
`default_nettype none

interface scb_if;

  // candidates at the queue head and final issue decisions
  logic [issue_pkg::UOP_W-1:0] cand0;
  logic [issue_pkg::UOP_W-1:0] cand1;
  logic go0;
  logic go1;

  // scoreboard verdicts
  logic stall0;
  logic stall1;
  logic [2*issue_pkg::FWD_W-1:0] fwd0;
  logic [2*issue_pkg::FWD_W-1:0] fwd1;

  modport issue (
    output cand0, cand1, go0, go1,
    input  stall0, stall1, fwd0, fwd1
  );

  modport scb (
    input  cand0, cand1, go0, go1,
    output stall0, stall1, fwd0, fwd1
  );

endinterface

`default_nettype wire

/* hdl/uop_queue.sv */
// fetch must hold a credit per push and push_v_i is only 00, 01 or 11; there is no overflow check
`default_nettype none

module uop_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  wire                          clk,
  input  wire                          resetn,

  input  wire  [1:0]                   push_v_i,
  input  wire  [issue_pkg::UOP_W-1:0]  push_uop0_i,
  input  wire  [issue_pkg::UOP_W-1:0]  push_uop1_i,
  output logic [1:0]                   crd_ret_o,

  uop_queue_if.queue                   q
);

  localparam int IDX_W = $clog2(QUEUE_DEPTH);

  logic [issue_pkg::UOP_W-1:0] mem [QUEUE_DEPTH];

  // one extra bit to tell full from empty
  logic [IDX_W:0]   wr_ptr;
  logic [IDX_W:0]   rd_ptr;
  logic [IDX_W:0]   occ;

  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] wr_idx1;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] rd_idx1;

  logic [1:0]       push_cnt;

  assign wr_idx  = wr_ptr[IDX_W-1:0];
  assign wr_idx1 = wr_idx + 1'b1;
  assign rd_idx  = rd_ptr[IDX_W-1:0];
  assign rd_idx1 = rd_idx + 1'b1;

  assign push_cnt = {1'b0, push_v_i[0]} + {1'b0, push_v_i[1]};

  // entries written in program order, uop0 first
  always_ff @(posedge clk) begin
    if (push_v_i[0]) begin
      mem[wr_idx] <= push_uop0_i;
    end
    if (push_v_i[1]) begin
      mem[wr_idx1] <= push_uop1_i;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr + {{(IDX_W-1){1'b0}}, push_cnt};
      rd_ptr <= rd_ptr + {{(IDX_W-1){1'b0}}, q.pop};
    end
  end

  assign occ = wr_ptr - rd_ptr;

  // anything above bit 0 means two or more entries
  assign q.avail = (occ[IDX_W:1] != '0) ? 2'd2 : occ[1:0];

  assign q.head0 = mem[rd_idx];
  assign q.head1 = mem[rd_idx1];

  // one credit back per retired entry, a cycle later
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      crd_ret_o <= 2'd0;
    end else begin
      crd_ret_o <= q.pop;
    end
  end

endmodule

`default_nettype wire

/* hdl/scoreboard.sv */
// registers stay busy until written back; no flush or rollback; a source busy past its ALU window stalls
`default_nettype none

module scoreboard (
  input  wire                              clk,
  input  wire                              resetn,

  scb_if.scb                               s,

  input  wire                              wb0_we_i,
  input  wire  [issue_pkg::REG_IDX_W-1:0]  wb0_rd_i,
  input  wire                              wb1_we_i,
  input  wire  [issue_pkg::REG_IDX_W-1:0]  wb1_rd_i,
  input  wire                              mu_done_i
);

  localparam int RW = issue_pkg::REG_IDX_W;
  localparam int CW = issue_pkg::UOP_CLS_W;
  localparam int NR = issue_pkg::NUM_REGS;
  localparam int FW = issue_pkg::FWD_W;

  logic [NR-1:0] busy;
  // result still in the ALU forwarding window
  logic [NR-1:0] win;
  // producer was slot 1
  logic [NR-1:0] src_slot1;
  logic          mu_wait;

  logic [RW-1:0] c_rd  [2];
  logic [CW-1:0] c_cls [2];
  logic          c_go  [2];

  function automatic logic uop_stall(input logic [issue_pkg::UOP_W-1:0] u,
                                     input logic [NR-1:0] bz,
                                     input logic [NR-1:0] wn,
                                     input logic mw);
    logic [RW-1:0] rs1;
    logic [RW-1:0] rs2;
    logic [RW-1:0] rd;
    logic [CW-1:0] cls;
    rs1 = u[issue_pkg::UOP_RS1_LSB +: RW];
    rs2 = u[issue_pkg::UOP_RS2_LSB +: RW];
    rd  = u[issue_pkg::UOP_RD_LSB +: RW];
    cls = u[issue_pkg::UOP_CLS_LSB +: CW];
    return (bz[rs1] && !wn[rs1]) || (bz[rs2] && !wn[rs2]) || bz[rd] ||
           (cls == issue_pkg::CLS_MULDIV && mw);
  endfunction

  function automatic logic [FW-1:0] src_fwd(input logic [RW-1:0] rs,
                                            input logic [NR-1:0] bz,
                                            input logic [NR-1:0] wn,
                                            input logic [NR-1:0] sl);
    if (bz[rs] && wn[rs]) begin
      return sl[rs] ? issue_pkg::FWD_SLOT1 : issue_pkg::FWD_SLOT0;
    end
    return issue_pkg::FWD_NONE;
  endfunction

  assign s.stall0 = uop_stall(s.cand0, busy, win, mu_wait);
  assign s.stall1 = uop_stall(s.cand1, busy, win, mu_wait);

  // rs2 select in the high field
  assign s.fwd0 = {src_fwd(s.cand0[issue_pkg::UOP_RS2_LSB +: RW], busy, win, src_slot1),
                   src_fwd(s.cand0[issue_pkg::UOP_RS1_LSB +: RW], busy, win, src_slot1)};
  assign s.fwd1 = {src_fwd(s.cand1[issue_pkg::UOP_RS2_LSB +: RW], busy, win, src_slot1),
                   src_fwd(s.cand1[issue_pkg::UOP_RS1_LSB +: RW], busy, win, src_slot1)};

  assign c_rd[0]  = s.cand0[issue_pkg::UOP_RD_LSB +: RW];
  assign c_rd[1]  = s.cand1[issue_pkg::UOP_RD_LSB +: RW];
  assign c_cls[0] = s.cand0[issue_pkg::UOP_CLS_LSB +: CW];
  assign c_cls[1] = s.cand1[issue_pkg::UOP_CLS_LSB +: CW];
  assign c_go[0]  = s.go0;
  assign c_go[1]  = s.go1;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      busy      <= '0;
      win       <= '0;
      src_slot1 <= '0;
      mu_wait   <= 1'b0;
    end else begin
      // window is open for a single cycle
      win <= '0;
      if (wb0_we_i) begin
        busy[wb0_rd_i] <= 1'b0;
      end
      if (wb1_we_i) begin
        busy[wb1_rd_i] <= 1'b0;
      end
      if (mu_done_i) begin
        mu_wait <= 1'b0;
      end
      // new issue wins over a stray release
      for (int k = 0; k < 2; k++) begin
        if (c_go[k] && c_rd[k] != '0 && c_cls[k] != issue_pkg::CLS_BRANCH &&
            c_cls[k] != issue_pkg::CLS_STORE) begin
          busy[c_rd[k]]      <= 1'b1;
          win[c_rd[k]]       <= (c_cls[k] == issue_pkg::CLS_ALU);
          src_slot1[c_rd[k]] <= (k == 1);
        end
        if (c_go[k] && c_cls[k] == issue_pkg::CLS_MULDIV) begin
          mu_wait <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/dual_issue.sv */
// in-order pairing only; slot 1 never issues without slot 0 and outputs have no back-pressure
`default_nettype none

module dual_issue (
  input  wire                                clk,
  input  wire                                resetn,

  uop_queue_if.issue                         q,
  scb_if.issue                               s,

  output logic                               iss0_v_o,
  output logic [issue_pkg::UOP_W-1:0]        iss0_uop_o,
  output logic [2*issue_pkg::FWD_W-1:0]      iss0_fwd_o,
  output logic                               iss1_v_o,
  output logic [issue_pkg::UOP_W-1:0]        iss1_uop_o,
  output logic [2*issue_pkg::FWD_W-1:0]      iss1_fwd_o
);

  localparam int RW = issue_pkg::REG_IDX_W;
  localparam int CW = issue_pkg::UOP_CLS_W;

  logic [RW-1:0] rd0;
  logic [RW-1:0] rd1;
  logic [RW-1:0] rs1_1;
  logic [RW-1:0] rs2_1;
  logic [CW-1:0] cls0;
  logic [CW-1:0] cls1;
  logic [1:0]    unit0;
  logic [1:0]    unit1;
  logic          data_ok;
  logic          unit_ok;
  logic          go0;
  logic          go1;

  // 0 means no shared unit, ALU and branch pair freely
  function automatic logic [1:0] exec_unit(input logic [CW-1:0] cls);
    case (cls)
      issue_pkg::CLS_LOAD,
      issue_pkg::CLS_STORE:  return 2'd1;
      issue_pkg::CLS_MULDIV: return 2'd2;
      issue_pkg::CLS_CSR:    return 2'd3;
      default:               return 2'd0;
    endcase
  endfunction

  assign s.cand0 = q.head0;
  assign s.cand1 = q.head1;

  assign rd0   = q.head0[issue_pkg::UOP_RD_LSB +: RW];
  assign cls0  = q.head0[issue_pkg::UOP_CLS_LSB +: CW];
  assign rd1   = q.head1[issue_pkg::UOP_RD_LSB +: RW];
  assign rs1_1 = q.head1[issue_pkg::UOP_RS1_LSB +: RW];
  assign rs2_1 = q.head1[issue_pkg::UOP_RS2_LSB +: RW];
  assign cls1  = q.head1[issue_pkg::UOP_CLS_LSB +: CW];

  assign unit0 = exec_unit(cls0);
  assign unit1 = exec_unit(cls1);

  // x0 as destination carries no dependence
  assign data_ok = (rd0 == '0) || (rs1_1 != rd0 && rs2_1 != rd0 && rd1 != rd0);
  assign unit_ok = (unit0 == 2'd0) || (unit0 != unit1);

  assign go0 = (q.avail != 2'd0) && !s.stall0;
  assign go1 = go0 && (q.avail == 2'd2) && !s.stall1 &&
               (cls0 != issue_pkg::CLS_BRANCH) && data_ok && unit_ok;

  assign q.pop = go1 ? 2'd2 : {1'b0, go0};
  assign s.go0 = go0;
  assign s.go1 = go1;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      iss0_v_o <= 1'b0;
      iss1_v_o <= 1'b0;
    end else begin
      iss0_v_o <= go0;
      iss1_v_o <= go1;
    end
  end

  always_ff @(posedge clk) begin
    if (go0) begin
      iss0_uop_o <= q.head0;
      iss0_fwd_o <= s.fwd0;
    end
    if (go1) begin
      iss1_uop_o <= q.head1;
      iss1_fwd_o <= s.fwd1;
    end
  end

endmodule

`default_nettype wire

/* hdl/issue_top.sv */
// fetch starts with QUEUE_DEPTH credits; push to issue output takes at least 2 cycles
`default_nettype none

module issue_top #(
  parameter int QUEUE_DEPTH = issue_pkg::DEF_QUEUE_DEPTH
) (
  input  wire                                clk,
  input  wire                                resetn,

  // fetch side
  input  wire  [1:0]                         push_v_i,
  input  wire  [issue_pkg::UOP_W-1:0]        push_uop0_i,
  input  wire  [issue_pkg::UOP_W-1:0]        push_uop1_i,
  output logic [1:0]                         crd_ret_o,

  // writeback and mul/div completion
  input  wire                                wb0_we_i,
  input  wire  [issue_pkg::REG_IDX_W-1:0]    wb0_rd_i,
  input  wire                                wb1_we_i,
  input  wire  [issue_pkg::REG_IDX_W-1:0]    wb1_rd_i,
  input  wire                                mu_done_i,

  // issued micro-ops
  output logic                               iss0_v_o,
  output logic [issue_pkg::UOP_W-1:0]        iss0_uop_o,
  output logic [2*issue_pkg::FWD_W-1:0]      iss0_fwd_o,
  output logic                               iss1_v_o,
  output logic [issue_pkg::UOP_W-1:0]        iss1_uop_o,
  output logic [2*issue_pkg::FWD_W-1:0]      iss1_fwd_o
);

  uop_queue_if q_if ();
  scb_if       s_if ();

  uop_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk         (clk),
    .resetn      (resetn),
    .push_v_i    (push_v_i),
    .push_uop0_i (push_uop0_i),
    .push_uop1_i (push_uop1_i),
    .crd_ret_o   (crd_ret_o),
    .q           (q_if.queue)
  );

  dual_issue u_issue (
    .clk        (clk),
    .resetn     (resetn),
    .q          (q_if.issue),
    .s          (s_if.issue),
    .iss0_v_o   (iss0_v_o),
    .iss0_uop_o (iss0_uop_o),
    .iss0_fwd_o (iss0_fwd_o),
    .iss1_v_o   (iss1_v_o),
    .iss1_uop_o (iss1_uop_o),
    .iss1_fwd_o (iss1_fwd_o)
  );

  scoreboard u_scb (
    .clk       (clk),
    .resetn    (resetn),
    .s         (s_if.scb),
    .wb0_we_i  (wb0_we_i),
    .wb0_rd_i  (wb0_rd_i),
    .wb1_we_i  (wb1_we_i),
    .wb1_rd_i  (wb1_rd_i),
    .mu_done_i (mu_done_i)
  );

endmodule

`default_nettype wire

/* verification/issue_tb_assert.sv */
// one checker bound twice; QUEUE_SIDE selects the properties that apply to each side
`default_nettype none

module issue_assert #(
  parameter bit QUEUE_SIDE = 1'b0
) (
  input wire       clk,
  input wire       resetn,
  input wire [1:0] pop,
  input wire [1:0] avail,
  input wire       v0,
  input wire       v1,
  input wire [1:0] crd
);
  timeunit 1ns;
  timeprecision 1ps;

  if (QUEUE_SIDE) begin : g_queue
    crd_le_two: assert property (@(posedge clk) disable iff (!resetn) crd <= 2'd2)
      else $error("credit return above 2");
  end else begin : g_issue
    pop_le_avail: assert property (@(posedge clk) disable iff (!resetn) pop <= avail)
      else $error("pop exceeds avail");

    // slot 1 alone on the outputs breaks program order
    slot1_needs_slot0: assert property (@(posedge clk) disable iff (!resetn) v1 |-> v0)
      else $error("slot 1 valid without slot 0");
  end

endmodule

bind dual_issue issue_assert #(.QUEUE_SIDE(1'b0)) issue_chk (
  .clk(clk), .resetn(resetn), .pop(q.pop), .avail(q.avail),
  .v0(iss0_v_o), .v1(iss1_v_o), .crd(2'd0)
);

bind uop_queue issue_assert #(.QUEUE_SIDE(1'b1)) queue_chk (
  .clk(clk), .resetn(resetn), .pop(q.pop), .avail(q.avail),
  .v0(1'b0), .v1(1'b0), .crd(crd_ret_o)
);

`default_nettype wire

/* verification/issue_tb.sv */
// rows run one after another with the queue drained in between; each row pushes one pair of micro-ops
`default_nettype none

module issue_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH = issue_pkg::DEF_QUEUE_DEPTH;
  localparam int NROWS = 9;
  localparam int UW = issue_pkg::UOP_W;
  localparam int TW = issue_pkg::UOP_TAG_W;
  localparam logic [2:0] ALU = issue_pkg::CLS_ALU;
  localparam logic [2:0] LD  = issue_pkg::CLS_LOAD;
  localparam logic [2:0] BR  = issue_pkg::CLS_BRANCH;
  localparam logic [2:0] MD  = issue_pkg::CLS_MULDIV;

  // ev: 0 none, 1 writeback port 0, 2 writeback port 1, 3 mul/div done
  typedef struct packed {
    logic [2:0] cls0;
    logic [4:0] rd0;
    logic [4:0] a0;
    logic [4:0] b0;
    logic [2:0] cls1;
    logic [4:0] rd1;
    logic [4:0] a1;
    logic [4:0] b1;
    logic [1:0] ev;
    logic [4:0] ev_rd;
    logic [3:0] ev_dly;
    logic after_ev;
    logic pair;
    logic [3:0] fwd0;
    logic [3:0] fwd1;
    logic clean_mu;
  } row_t;

  logic clk;
  logic resetn;
  logic [1:0] push_v_i;
  logic [UW-1:0] push_uop0_i;
  logic [UW-1:0] push_uop1_i;
  logic [1:0] crd_ret_o;
  logic wb0_we_i;
  logic [4:0] wb0_rd_i;
  logic wb1_we_i;
  logic [4:0] wb1_rd_i;
  logic mu_done_i;
  logic iss0_v_o;
  logic [UW-1:0] iss0_uop_o;
  logic [3:0] iss0_fwd_o;
  logic iss1_v_o;
  logic [UW-1:0] iss1_uop_o;
  logic [3:0] iss1_fwd_o;

  row_t rows [NROWS];
  logic [UW-1:0] rec_uop [$];
  logic rec_pair [$];
  logic [3:0] rec_fwd [$];
  int rec_cyc [$];
  int cyc;
  int crd_sum;
  int pushed;
  int errors;
  int row_err;
  int tag_cnt;
  int seed;

  issue_top #(.QUEUE_DEPTH(DEPTH)) dut_i (
    .clk(clk), .resetn(resetn),
    .push_v_i(push_v_i), .push_uop0_i(push_uop0_i), .push_uop1_i(push_uop1_i),
    .crd_ret_o(crd_ret_o),
    .wb0_we_i(wb0_we_i), .wb0_rd_i(wb0_rd_i), .wb1_we_i(wb1_we_i), .wb1_rd_i(wb1_rd_i),
    .mu_done_i(mu_done_i),
    .iss0_v_o(iss0_v_o), .iss0_uop_o(iss0_uop_o), .iss0_fwd_o(iss0_fwd_o),
    .iss1_v_o(iss1_v_o), .iss1_uop_o(iss1_uop_o), .iss1_fwd_o(iss1_fwd_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc = cyc + 1;
  end

  // outputs settle after the edge, sampled mid-cycle
  always @(negedge clk) begin
    if (resetn) begin
      crd_sum = crd_sum + int'(crd_ret_o);
      if (iss0_v_o) begin
        rec_uop.push_back(iss0_uop_o);
        rec_pair.push_back(iss1_v_o);
        rec_fwd.push_back(iss0_fwd_o);
        rec_cyc.push_back(cyc);
      end
      if (iss1_v_o) begin
        rec_uop.push_back(iss1_uop_o);
        rec_pair.push_back(1'b1);
        rec_fwd.push_back(iss1_fwd_o);
        rec_cyc.push_back(cyc);
      end
    end
  end

  initial begin
    repeat (NROWS * 40 + 200) @(posedge clk);
    $display("=== FAIL ===");
    $display("timeout: the issue stage stopped issuing before all tests finished");
    $finish;
  end

  task automatic check(input string what, input int got, input int exp);
    if (got !== exp) begin
      errors++;
      row_err++;
      $display("Fail %0d ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [UW-1:0] make_uop(input logic [TW-1:0] tag, input logic [2:0] cls,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    logic [UW-1:0] u;
    u = '0;
    u[issue_pkg::UOP_RD_LSB +: 5]  = rd;
    u[issue_pkg::UOP_RS1_LSB +: 5] = rs1;
    u[issue_pkg::UOP_RS2_LSB +: 5] = rs2;
    u[issue_pkg::UOP_CLS_LSB +: 3] = cls;
    u[issue_pkg::UOP_TAG_LSB +: TW] = tag;
    return u;
  endfunction

  task automatic run_row(input int r);
    row_t w;
    logic [TW-1:0] t0;
    logic [TW-1:0] t1;
    logic [UW-1:0] u0;
    logic [UW-1:0] u1;
    int base_n;
    int k;
    int ev_cyc;
    int filler;
    w = rows[r];
    row_err = 0;
    // upper tag bits are filler, lower bits count
    filler = $random(seed);
    t0 = {filler[2:0], tag_cnt[4:0]};
    tag_cnt++;
    t1 = {filler[6:4], tag_cnt[4:0]};
    tag_cnt++;
    u0 = make_uop(t0, w.cls0, w.rd0, w.a0, w.b0);
    u1 = make_uop(t1, w.cls1, w.rd1, w.a1, w.b1);
    base_n = rec_uop.size();
    while (DEPTH - pushed + crd_sum < 2) begin
      @(posedge clk);
      #2;
    end
    push_v_i = 2'b11;
    push_uop0_i = u0;
    push_uop1_i = u1;
    pushed += 2;
    @(posedge clk);
    #2;
    push_v_i = 2'b00;
    k = 1;
    ev_cyc = 32'h7fffffff;
    while (rec_uop.size() < base_n + 2) begin
      if (w.ev != 2'd0 && k == int'(w.ev_dly)) begin
        ev_cyc = cyc;
        wb0_we_i = (w.ev == 2'd1);
        wb1_we_i = (w.ev == 2'd2);
        mu_done_i = (w.ev == 2'd3);
        wb0_rd_i = w.ev_rd;
        wb1_rd_i = w.ev_rd;
      end
      @(posedge clk);
      #2;
      wb0_we_i = 1'b0;
      wb1_we_i = 1'b0;
      mu_done_i = 1'b0;
      k++;
    end
    check("slot order uop 0", rec_uop[base_n], u0);
    check("slot order uop 1", rec_uop[base_n+1], u1);
    check("pairing 0", rec_pair[base_n], w.pair);
    check("pairing 1", rec_pair[base_n+1], w.pair);
    check("forward select 0", rec_fwd[base_n], w.fwd0);
    check("forward select 1", rec_fwd[base_n+1], w.fwd1);
    if (w.after_ev) begin
      check("issued after event", int'(rec_cyc[base_n+1] > ev_cyc), 1);
    end
    // release whatever the row left busy
    wb0_we_i = 1'b1;
    wb0_rd_i = w.rd0;
    wb1_we_i = 1'b1;
    wb1_rd_i = w.rd1;
    mu_done_i = w.clean_mu;
    @(posedge clk);
    #2;
    wb0_we_i = 1'b0;
    wb1_we_i = 1'b0;
    mu_done_i = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    $display("test %0d: %s", r, (row_err == 0) ? "ok" : "mismatch");
  endtask

  initial begin
    rows[0] = '{ALU, 1, 20, 21, ALU, 2, 22, 23, 0, 0, 0, 0, 1, 0, 0, 1};
    rows[1] = '{ALU, 3, 20, 21, ALU, 4, 3, 22, 0, 0, 0, 0, 0, 0, 4'b0001, 1};
    rows[2] = '{ALU, 3, 20, 21, ALU, 3, 22, 23, 2, 3, 6, 1, 0, 0, 0, 1};
    rows[3] = '{LD, 12, 20, 0, LD, 13, 21, 0, 0, 0, 0, 0, 0, 0, 0, 1};
    rows[4] = '{BR, 0, 20, 21, ALU, 14, 22, 23, 0, 0, 0, 0, 0, 0, 0, 1};
    rows[5] = '{ALU, 0, 20, 21, ALU, 15, 0, 22, 0, 0, 0, 0, 1, 0, 0, 1};
    rows[6] = '{LD, 5, 20, 0, ALU, 16, 5, 21, 1, 5, 6, 1, 0, 0, 0, 1};
    // mul/div left pending for the next row
    rows[7] = '{MD, 8, 20, 21, ALU, 9, 22, 23, 0, 0, 0, 0, 1, 0, 0, 0};
    rows[8] = '{ALU, 10, 20, 21, MD, 11, 22, 23, 3, 0, 6, 1, 0, 0, 0, 1};
    seed = 32'h84a0;
    clk = 1'b0;
    resetn = 1'b0;
    push_v_i = 2'b00;
    push_uop0_i = '0;
    push_uop1_i = '0;
    wb0_we_i = 1'b0;
    wb0_rd_i = '0;
    wb1_we_i = 1'b0;
    wb1_rd_i = '0;
    mu_done_i = 1'b0;
    cyc = 0;
    crd_sum = 0;
    pushed = 0;
    errors = 0;
    tag_cnt = 0;
    repeat (8) @(posedge clk);
    #2;
    resetn = 1'b1;
    @(posedge clk);
    #2;
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end
    repeat (3) @(posedge clk);
    check("credits returned", crd_sum, rec_uop.size());
    check("issued count", rec_uop.size(), pushed);
    $display("tests %0d, failed checks %0d", NROWS, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hdl/issue_pkg.sv
hdl/uop_queue_if.sv
hdl/scb_if.sv
hdl/uop_queue.sv
hdl/scoreboard.sv
hdl/dual_issue.sv
hdl/issue_top.sv
verification/issue_tb_assert.sv
verification/issue_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = issue_tb
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
